// ==== rtl/lsu_defs.svh ====
// LSU build parameters
// Data width, bus timeout length and timer width shared by the RTL

`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// Data and address width, doubleword access not supported
`define LSU_XLEN 32

// ACCESS cycles without pready before the transfer is aborted
`define LSU_TIMEOUT_CYCLES 16

// Timer counter width, must hold LSU_TIMEOUT_CYCLES - 1
`define LSU_TIMER_W 5

`endif

// ==== rtl/lsu_pkg.sv ====
// LSU type package
// Access size and completion cause codes, FSM states and the
// bus word views used for load lane extraction

`include "lsu_defs.svh"

package lsu_pkg;

  // Access size, code 3 is reserved and always misaligned
  typedef enum logic [1:0] {
    BYTE  = 2'd0,
    HWORD = 2'd1,
    WORD  = 2'd2
  } lsu_size_t;

  // Completion cause reported with done
  typedef enum logic [1:0] {
    CAUSE_NONE       = 2'd0,
    CAUSE_MISALIGNED = 2'd1,
    CAUSE_BUS_ERR    = 2'd2,
    CAUSE_TIMEOUT    = 2'd3
  } lsu_cause_t;

  // Access sequencer states
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_CHECK,
    ST_SETUP,
    ST_ACCESS,
    ST_RESP
  } lsu_state_t;

  // One bus word, seen whole, per byte lane or per halfword lane
  typedef union packed {
    logic [`LSU_XLEN-1:0] w;
    logic [3:0][7:0]      b;
    logic [1:0][15:0]     h;
  } lsu_word_u;

endpackage

// ==== rtl/lsu_misalign_chk.sv ====
// LSU misalignment check
// Decodes fetch and data alignment from the raw request and
// registers the verdict one cycle after acceptance

`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_misalign_chk #(
  parameter int HAS_RVC = 0
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 instruction_i,
  input  logic                 req_i,
  input  logic [`LSU_XLEN-1:0] adr_i,
  input  lsu_pkg::lsu_size_t   size_i,
  output logic                 misaligned_o
);
  import lsu_pkg::*;

  logic misaligned;

  // Fetch needs halfword alignment with compressed code and word alignment otherwise
  // Data needs natural alignment by size so nothing crosses a bus word
  always_comb begin
    if (instruction_i) begin
      misaligned = (HAS_RVC != 0) ? adr_i[0] : |adr_i[1:0];
    end else begin
      case (size_i)
        BYTE:    misaligned = 1'b0;
        HWORD:   misaligned = adr_i[0];
        WORD:    misaligned = |adr_i[1:0];
        // Reserved size code
        default: misaligned = 1'b1;
      endcase
    end
  end

  // Verdict only for an accepted request
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      misaligned_o <= 1'b0;
    end else begin
      misaligned_o <= req_i & misaligned;
    end
  end

  // A verdict needs a request with a low address bit set or the reserved data size
  a_no_spurious_verdict: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    misaligned_o |-> $past(req_i && (|adr_i[1:0] || (!instruction_i && size_i == 2'd3)))
  );

endmodule

// ==== rtl/lsu_bus_timer.sv ====
// LSU bus timer
// Counts wait states of a running APB transfer and flags one
// that has gone on too long without pready

`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_bus_timer (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic run_i,
  output logic expired_o
);

  // Count value in the last allowed ACCESS cycle
  localparam logic [`LSU_TIMER_W-1:0] LAST_CNT = `LSU_TIMEOUT_CYCLES - 1;

  logic [`LSU_TIMER_W-1:0] count_q;

  // Clears between transfers and holds once expired
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      count_q <= '0;
    end else if (!run_i) begin
      count_q <= '0;
    end else if (!expired_o) begin
      count_q <= count_q + 1'b1;
    end
  end

  // High in the LSU_TIMEOUT_CYCLES-th running cycle
  assign expired_o = run_i && (count_q == LAST_CNT);

  ////////////////////////////////////////////////////
  // Transfer already running LSU_TIMEOUT_CYCLES - 1 cycles before expiry
  a_expired_in_run: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    expired_o |-> $past(run_i, `LSU_TIMEOUT_CYCLES - 1)
  );

endmodule

// ==== rtl/lsu_lane_align.sv ====
// LSU lane alignment
// Store side replicates byte or halfword data over all lanes and
// builds the APB4 byte strobes
// Load side picks the addressed lane from prdata, extends it and
// captures the result when the transfer completes

`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_lane_align (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic [1:0]           adr_lo_i,
  input  lsu_pkg::lsu_size_t   size_i,
  input  logic                 unsigned_i,
  input  logic                 write_i,
  input  logic [`LSU_XLEN-1:0] wdata_i,
  input  logic                 capture_i,
  input  logic [`LSU_XLEN-1:0] prdata_i,
  output logic [`LSU_XLEN-1:0] pwdata_o,
  output logic [3:0]           pstrb_o,
  output logic [`LSU_XLEN-1:0] rdata_o
);
  import lsu_pkg::*;

  lsu_word_u            rd_word;
  logic [7:0]           rd_byte;
  logic [15:0]          rd_half;
  logic [`LSU_XLEN-1:0] load_ext;
  logic [3:0]           strb;

  ////////////////////////////////////////////////////
  // Store steering
  always_comb begin
    case (size_i)
      BYTE: begin
        pwdata_o = {4{wdata_i[7:0]}};
        strb     = 4'b0001 << adr_lo_i;
      end
      HWORD: begin
        pwdata_o = {2{wdata_i[15:0]}};
        strb     = adr_lo_i[1] ? 4'b1100 : 4'b0011;
      end
      WORD: begin
        pwdata_o = wdata_i;
        strb     = 4'b1111;
      end
      default: begin
        pwdata_o = wdata_i;
        strb     = 4'b0000;
      end
    endcase
  end

  // APB4 wants no strobes on reads
  assign pstrb_o = write_i ? strb : 4'b0000;

  ////////////////////////////////////////////////////
  // Load extraction
  assign rd_word = prdata_i;
  assign rd_byte = rd_word.b[adr_lo_i];
  assign rd_half = rd_word.h[adr_lo_i[1]];

  always_comb begin
    case (size_i)
      BYTE:    load_ext = {{(`LSU_XLEN-8){rd_byte[7] & ~unsigned_i}}, rd_byte};
      HWORD:   load_ext = {{(`LSU_XLEN-16){rd_half[15] & ~unsigned_i}}, rd_half};
      default: load_ext = rd_word.w;
    endcase
  end

  // Load result holds until the next completed read
  always_ff @(posedge clk_i) begin
    if (capture_i) begin
      rdata_o <= load_ext;
    end
  end

  // Legal strobe shape per size on writes
  function automatic logic strb_legal(lsu_size_t sz, logic [3:0] s);
    case (sz)
      BYTE:    return $onehot(s);
      HWORD:   return (s == 4'b0011) || (s == 4'b1100);
      WORD:    return s == 4'b1111;
      default: return s == 4'b0000;
    endcase
  endfunction

  // Write strobes also cover the addressed byte for every legal size
  a_strb_legal: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    write_i |-> strb_legal(size_i, pstrb_o) && (size_i == 2'd3 || pstrb_o[adr_lo_i])
  );

endmodule

// ==== rtl/lsu_ctrl_fsm.sv ====
// LSU access controller
// Latches a CPU request, waits for the alignment verdict and runs
// one APB4 transfer, then reports completion with a cause code

`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_ctrl_fsm (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  // CPU request
  input  logic                 req_i,
  input  logic                 we_i,
  input  logic                 instruction_i,
  input  logic [`LSU_XLEN-1:0] adr_i,
  input  lsu_pkg::lsu_size_t   size_i,
  input  logic                 unsigned_i,
  input  logic [`LSU_XLEN-1:0] wdata_i,
  output logic                 busy_o,
  output logic                 done_o,
  output logic                 err_o,
  output lsu_pkg::lsu_cause_t  cause_o,
  // Helper blocks
  output logic                 accept_o,
  input  logic                 misaligned_i,
  output logic                 run_o,
  input  logic                 expired_i,
  output logic                 capture_o,
  output logic [1:0]           adr_lo_o,
  output lsu_pkg::lsu_size_t   size_o,
  output logic                 unsigned_o,
  output logic [`LSU_XLEN-1:0] wdata_o,
  // APB master
  output logic                 psel_o,
  output logic                 penable_o,
  output logic                 pwrite_o,
  output logic [`LSU_XLEN-1:0] paddr_o,
  input  logic                 pready_i,
  input  logic                 pslverr_i
);
  import lsu_pkg::*;

  lsu_state_t           state_q;
  lsu_state_t           state_d;
  lsu_cause_t           cause_q;
  lsu_cause_t           cause_d;
  logic                 we_q;
  logic [`LSU_XLEN-1:0] adr_q;
  lsu_size_t            size_q;
  logic                 unsigned_q;
  logic [`LSU_XLEN-1:0] wdata_q;

  ////////////////////////////////////////////////////
  // Next state and cause
  always_comb begin
    state_d = state_q;
    cause_d = cause_q;
    case (state_q)
      ST_IDLE: begin
        if (accept_o) begin
          state_d = ST_CHECK;
          cause_d = CAUSE_NONE;
        end
      end
      // Verdict is registered, valid here
      ST_CHECK: begin
        if (misaligned_i) begin
          state_d = ST_RESP;
          cause_d = CAUSE_MISALIGNED;
        end else begin
          state_d = ST_SETUP;
        end
      end
      ST_SETUP: state_d = ST_ACCESS;
      // pready wins over a timeout in the same cycle
      ST_ACCESS: begin
        if (pready_i) begin
          state_d = ST_RESP;
          cause_d = pslverr_i ? CAUSE_BUS_ERR : CAUSE_NONE;
        end else if (expired_i) begin
          state_d = ST_RESP;
          cause_d = CAUSE_TIMEOUT;
        end
      end
      ST_RESP: state_d = ST_IDLE;
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= ST_IDLE;
      cause_q <= CAUSE_NONE;
      we_q    <= 1'b0;
    end else begin
      state_q <= state_d;
      cause_q <= cause_d;
      // A fetch never writes
      if (accept_o) begin
        we_q <= we_i & ~instruction_i;
      end
    end
  end

  // Request payload
  always_ff @(posedge clk_i) begin
    if (accept_o) begin
      adr_q      <= adr_i;
      size_q     <= size_i;
      unsigned_q <= unsigned_i;
      wdata_q    <= wdata_i;
    end
  end

  ////////////////////////////////////////////////////
  // CPU side
  assign busy_o   = (state_q != ST_IDLE);
  assign accept_o = req_i & ~busy_o;
  assign done_o   = (state_q == ST_RESP);
  assign err_o    = done_o && (cause_q != CAUSE_NONE);
  assign cause_o  = cause_q;

  // Helper blocks
  assign run_o      = (state_q == ST_ACCESS);
  assign capture_o  = run_o & pready_i;
  assign adr_lo_o   = adr_q[1:0];
  assign size_o     = size_q;
  assign unsigned_o = unsigned_q;
  assign wdata_o    = wdata_q;

  // APB control, word aligned address
  assign psel_o    = (state_q == ST_SETUP) || (state_q == ST_ACCESS);
  assign penable_o = run_o;
  assign pwrite_o  = we_q;
  assign paddr_o   = {adr_q[`LSU_XLEN-1:2], 2'b00};

  // ACCESS always follows a SETUP cycle of the same transfer
  a_penable_after_setup: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    $rose(penable_o) |-> psel_o && $past(psel_o && !penable_o)
  );

  // Address and direction hold through wait states
  a_paddr_stable: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    psel_o && !pready_i |=> $stable(paddr_o) && $stable(pwrite_o)
  );

endmodule

// ==== rtl/lsu_top.sv ====
// LSU top level
// Load/store access unit, CPU request port to an APB4 master port
// Misaligned requests complete without a bus transfer, all others
// run as a single APB4 transfer guarded by a timeout

`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_top #(
  parameter int HAS_RVC = 0
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  // CPU side
  input  logic                 req_i,
  input  logic                 we_i,
  input  logic                 instruction_i,
  input  logic [`LSU_XLEN-1:0] adr_i,
  input  lsu_pkg::lsu_size_t   size_i,
  input  logic                 unsigned_i,
  input  logic [`LSU_XLEN-1:0] wdata_i,
  output logic                 busy_o,
  output logic                 done_o,
  output logic                 err_o,
  output lsu_pkg::lsu_cause_t  cause_o,
  output logic [`LSU_XLEN-1:0] rdata_o,
  // APB4 master
  output logic                 psel_o,
  output logic                 penable_o,
  output logic                 pwrite_o,
  output logic [`LSU_XLEN-1:0] paddr_o,
  output logic [`LSU_XLEN-1:0] pwdata_o,
  output logic [3:0]           pstrb_o,
  input  logic [`LSU_XLEN-1:0] prdata_i,
  input  logic                 pready_i,
  input  logic                 pslverr_i
);
  import lsu_pkg::*;

  logic                 accept;
  logic                 misaligned;
  logic                 run;
  logic                 expired;
  logic                 capture;
  logic [1:0]           adr_lo;
  lsu_size_t            size_lat;
  logic                 unsigned_lat;
  logic [`LSU_XLEN-1:0] wdata_lat;

  lsu_ctrl_fsm u_ctrl (
    .clk_i, .arst_n_i, .req_i, .we_i, .instruction_i, .adr_i, .size_i,
    .unsigned_i, .wdata_i, .busy_o, .done_o, .err_o, .cause_o,
    .accept_o     (accept),
    .misaligned_i (misaligned),
    .run_o        (run),
    .expired_i    (expired),
    .capture_o    (capture),
    .adr_lo_o     (adr_lo),
    .size_o       (size_lat),
    .unsigned_o   (unsigned_lat),
    .wdata_o      (wdata_lat),
    .psel_o, .penable_o, .pwrite_o, .paddr_o, .pready_i, .pslverr_i
  );

  // Checks the raw request in the accepting cycle
  lsu_misalign_chk #(
    .HAS_RVC (HAS_RVC)
  ) u_misalign (
    .clk_i, .arst_n_i, .instruction_i,
    .req_i        (accept),
    .adr_i, .size_i,
    .misaligned_o (misaligned)
  );

  lsu_bus_timer u_timer (
    .clk_i, .arst_n_i,
    .run_i     (run),
    .expired_o (expired)
  );

  // Works on the latched request
  lsu_lane_align u_lanes (
    .clk_i, .arst_n_i,
    .adr_lo_i   (adr_lo),
    .size_i     (size_lat),
    .unsigned_i (unsigned_lat),
    .write_i    (pwrite_o),
    .wdata_i    (wdata_lat),
    .capture_i  (capture),
    .prdata_i, .pwdata_o, .pstrb_o, .rdata_o
  );

endmodule

// ==== bench/lsu_apb_mem.sv ====
// APB4 memory model
// 64 words, wait states taken from address bits 5:4
// Error region at 0x100 answers pslverr, dead region at 0x200
// never answers pready

`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_apb_mem (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 psel_i,
  input  logic                 penable_i,
  input  logic                 pwrite_i,
  input  logic [`LSU_XLEN-1:0] paddr_i,
  input  logic [`LSU_XLEN-1:0] pwdata_i,
  input  logic [3:0]           pstrb_i,
  output logic [`LSU_XLEN-1:0] prdata_o,
  output logic                 pready_o,
  output logic                 pslverr_o
);

  logic [`LSU_XLEN-1:0] mem [0:63];
  logic [1:0]           wait_q;
  logic                 access;
  logic                 mem_region;
  logic                 err_region;
  logic                 dead_region;

  // Address decode, 256 bytes per region
  assign access      = psel_i & penable_i;
  assign mem_region  = (paddr_i[`LSU_XLEN-1:8] == 0);
  assign err_region  = (paddr_i[`LSU_XLEN-1:8] == 1);
  assign dead_region = (paddr_i[`LSU_XLEN-1:8] == 2);

  // Ready once the wait count matches bits 5:4
  assign pready_o  = access && !dead_region && (wait_q == paddr_i[5:4]);
  assign pslverr_o = pready_o && err_region;
  assign prdata_o  = mem[paddr_i[7:2]];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wait_q <= '0;
    end else if (access && !pready_o) begin
      wait_q <= wait_q + 1'b1;
    end else begin
      wait_q <= '0;
    end
  end

  // Fill pattern spreads the word address over all bits
  initial begin
    for (int i = 0; i < 64; i++) begin
      mem[i] = 32'h9e37_79b9 * (i * 4 + 1);
    end
  end

  // Byte lanes written per strobe, only in the memory region
  always @(posedge clk_i) begin
    if (pready_o && pwrite_i && mem_region) begin
      for (int k = 0; k < 4; k++) begin
        if (pstrb_i[k]) begin
          mem[paddr_i[7:2]][8*k +: 8] <= pwdata_i[8*k +: 8];
        end
      end
    end
  end

endmodule

// ==== bench/lsu_tb.sv ====
// LSU testbench
// Runs word, byte and halfword accesses, misaligned requests,
// fetches and bus faults through the LSU into an APB4 memory model
// Results are checked by concurrent assertions against a byte reference

`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_tb;
  import lsu_pkg::*;

  // Requests issued over all tests
  localparam int N_REQ      = 23;
  localparam int REQ_CYCLES = `LSU_TIMEOUT_CYCLES + 8;

  logic                 clk = 1'b0;
  logic                 arst_n;
  logic                 req;
  logic                 we;
  logic                 fetch;
  logic [`LSU_XLEN-1:0] adr;
  lsu_size_t            size;
  logic                 uns;
  logic [`LSU_XLEN-1:0] wdata;
  logic                 busy;
  logic                 done;
  logic                 err;
  lsu_cause_t           cause;
  logic [`LSU_XLEN-1:0] rdata;
  logic                 psel;
  logic                 penable;
  logic                 pwrite;
  logic [`LSU_XLEN-1:0] paddr;
  logic [`LSU_XLEN-1:0] pwdata;
  logic [3:0]           pstrb;
  logic [`LSU_XLEN-1:0] prdata;
  logic                 pready;
  logic                 pslverr;

  // Expected response of the request in flight
  lsu_cause_t           exp_cause;
  logic                 exp_write;
  logic                 exp_no_bus;
  logic                 chk_rdata;
  logic [`LSU_XLEN-1:0] exp_rdata;
  logic [`LSU_XLEN-1:0] exp_pwdata;
  logic [`LSU_XLEN-1:0] exp_paddr;
  logic [3:0]           exp_strb;

  // Reference copy of the memory region
  logic [7:0] ref_mem [0:255];
  int         seed = 68300;
  int         errors;
  int         errs_at_start;
  int         pass_cnt;
  int         fail_cnt;
  logic [31:0] d;

  always #4 clk = ~clk;

  lsu_top #(
    .HAS_RVC (0)
  ) i_dut (
    .clk_i (clk), .arst_n_i (arst_n), .req_i (req), .we_i (we),
    .instruction_i (fetch), .adr_i (adr), .size_i (size), .unsigned_i (uns),
    .wdata_i (wdata), .busy_o (busy), .done_o (done), .err_o (err),
    .cause_o (cause), .rdata_o (rdata), .psel_o (psel), .penable_o (penable),
    .pwrite_o (pwrite), .paddr_o (paddr), .pwdata_o (pwdata), .pstrb_o (pstrb),
    .prdata_i (prdata), .pready_i (pready), .pslverr_i (pslverr)
  );

  lsu_apb_mem u_mem (
    .clk_i (clk), .arst_n_i (arst_n), .psel_i (psel), .penable_i (penable),
    .pwrite_i (pwrite), .paddr_i (paddr), .pwdata_i (pwdata), .pstrb_i (pstrb),
    .prdata_o (prdata), .pready_o (pready), .pslverr_o (pslverr)
  );

  //////////////////////////////////////////////////
  // Completion checks
  a_done_cause: assert property (@(posedge clk) disable iff (!arst_n)
    done |-> cause == exp_cause)
    else begin
      $display("** Error: cause_o expected %h, got %h", exp_cause, $sampled(cause));
      errors++;
    end

  a_done_err: assert property (@(posedge clk) disable iff (!arst_n)
    done |-> err == (exp_cause != CAUSE_NONE))
    else begin
      $display("** Error: err_o expected %h, got %h", exp_cause != CAUSE_NONE,
               $sampled(err));
      errors++;
    end

  a_load_data: assert property (@(posedge clk) disable iff (!arst_n)
    done && chk_rdata |-> rdata == exp_rdata)
    else begin
      $display("** Error: rdata_o expected %h, got %h", exp_rdata, $sampled(rdata));
      errors++;
    end

  //////////////////////////////////////////////////
  // Bus side checks
  a_bus_addr: assert property (@(posedge clk) disable iff (!arst_n)
    psel |-> paddr == exp_paddr)
    else begin
      $display("** Error: paddr_o expected %h, got %h", exp_paddr, $sampled(paddr));
      errors++;
    end

  a_store_strb: assert property (@(posedge clk) disable iff (!arst_n)
    psel && penable && pwrite |-> pstrb == exp_strb)
    else begin
      $display("** Error: pstrb_o expected %h, got %h", exp_strb, $sampled(pstrb));
      errors++;
    end

  a_store_lanes: assert property (@(posedge clk) disable iff (!arst_n)
    psel && penable && pwrite |-> pwdata == exp_pwdata)
    else begin
      $display("** Error: pwdata_o expected %h, got %h", exp_pwdata, $sampled(pwdata));
      errors++;
    end

  a_read_strb: assert property (@(posedge clk) disable iff (!arst_n)
    psel && !pwrite |-> pstrb == 4'h0)
    else begin
      $display("** Error: pstrb_o expected 0, got %h", $sampled(pstrb));
      errors++;
    end

  // Fetches never write
  a_direction: assert property (@(posedge clk) disable iff (!arst_n)
    psel |-> pwrite == exp_write)
    else begin
      $display("** Error: pwrite_o expected %h, got %h", exp_write, $sampled(pwrite));
      errors++;
    end

  a_misaligned_no_bus: assert property (@(posedge clk) disable iff (!arst_n)
    exp_no_bus |-> !psel)
    else begin
      $display("** Error: psel_o expected 0, got %h", $sampled(psel));
      errors++;
    end

  a_misaligned_latency: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(busy) && exp_no_bus |=> done)
    else begin
      $display("Misaligned request did not complete two cycles after acceptance");
      errors++;
    end

  // Bus released and FSM idle after an aborted transfer
  a_timeout_release: assert property (@(posedge clk) disable iff (!arst_n)
    done && cause == CAUSE_TIMEOUT |-> !psel ##1 (i_dut.u_ctrl.state_q == ST_IDLE))
    else begin
      $display("Bus was not released after a timeout");
      errors++;
    end

  //////////////////////////////////////////////////
  // One request with expectations set from the lane rules
  task automatic do_access(input logic we_v, input logic fetch_v,
                           input logic [31:0] adr_v, input lsu_size_t size_v,
                           input logic uns_v, input logic [31:0] data_v,
                           input lsu_cause_t cause_v);
    int          nbytes;
    int          cycles;
    int          k;
    logic [31:0] load_v;
    nbytes     = (size_v == BYTE) ? 1 : (size_v == HWORD) ? 2 : 4;
    exp_cause  = cause_v;
    exp_no_bus = (cause_v == CAUSE_MISALIGNED);
    exp_write  = we_v & ~fetch_v;
    // Bus address is the word that holds the request
    exp_paddr  = adr_v & ~32'h3;
    // Strobes cover the addressed bytes
    // Data repeats per access width
    exp_strb = '0;
    for (k = 0; k < 4; k++) begin
      if (k >= adr_v[1:0] && k < adr_v[1:0] + nbytes) begin
        exp_strb[k] = 1'b1;
      end
      exp_pwdata[8*k +: 8] = data_v[8*(k % nbytes) +: 8];
    end
    // Load value from the reference with sign or zero extension
    load_v = '0;
    for (k = 0; k < nbytes; k++) begin
      load_v[8*k +: 8] = ref_mem[adr_v[7:0] + k];
    end
    if (!uns_v && nbytes < 4 && load_v[8*nbytes-1]) begin
      for (k = nbytes; k < 4; k++) begin
        load_v[8*k +: 8] = 8'hff;
      end
    end
    exp_rdata = load_v;
    chk_rdata = !exp_write && (cause_v == CAUSE_NONE);
    req   = 1'b1;
    we    = we_v;
    fetch = fetch_v;
    adr   = adr_v;
    size  = size_v;
    uns   = uns_v;
    wdata = data_v;
    @(posedge clk);
    #1;
    req    = 1'b0;
    cycles = 0;
    while (!done && cycles < REQ_CYCLES) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (!done) begin
      $display("Request to %h did not complete within %0d cycles", adr_v, REQ_CYCLES);
      errors++;
    end else if (exp_write && cause_v == CAUSE_NONE) begin
      for (k = 0; k < nbytes; k++) begin
        ref_mem[adr_v[7:0] + k] = data_v[8*k +: 8];
      end
    end
    // Let the completion checks sample before the next request
    @(posedge clk);
    #1;
  endtask

  task automatic begin_test();
    errs_at_start = errors;
  endtask

  task automatic report_test(input string name);
    if (errors == errs_at_start) begin
      pass_cnt++;
      $display("PASS  %s", name);
    end else begin
      fail_cnt++;
      $display("FAIL  %s, %0d errors", name, errors - errs_at_start);
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus
  initial begin
    arst_n     = 1'b0;
    req        = 1'b0;
    we         = 1'b0;
    fetch      = 1'b0;
    adr        = '0;
    size       = BYTE;
    uns        = 1'b0;
    wdata      = '0;
    exp_cause  = CAUSE_NONE;
    exp_write  = 1'b0;
    exp_no_bus = 1'b0;
    chk_rdata  = 1'b0;
    exp_rdata  = '0;
    exp_pwdata = '0;
    exp_paddr  = '0;
    exp_strb   = '0;
    errors     = 0;
    pass_cnt   = 0;
    fail_cnt   = 0;
    repeat (2) @(posedge clk);
    #1;
    arst_n = 1'b1;

    begin_test();
    d = $random(seed);
    do_access(1'b1, 1'b0, 32'h10, WORD, 1'b0, d, CAUSE_NONE);
    do_access(1'b0, 1'b0, 32'h10, WORD, 1'b0, '0, CAUSE_NONE);
    d = $random(seed);
    do_access(1'b1, 1'b0, 32'h34, WORD, 1'b0, d, CAUSE_NONE);
    do_access(1'b0, 1'b0, 32'h34, WORD, 1'b0, '0, CAUSE_NONE);
    report_test("word store then word load");

    // Negative byte and halfword so sign extension shows
    begin_test();
    d = $random(seed);
    do_access(1'b1, 1'b0, 32'h20, WORD, 1'b0, d, CAUSE_NONE);
    d = $random(seed) | 32'h80;
    do_access(1'b1, 1'b0, 32'h21, BYTE, 1'b0, d, CAUSE_NONE);
    d = $random(seed) | 32'h8000;
    do_access(1'b1, 1'b0, 32'h22, HWORD, 1'b0, d, CAUSE_NONE);
    do_access(1'b0, 1'b0, 32'h21, BYTE, 1'b0, '0, CAUSE_NONE);
    do_access(1'b0, 1'b0, 32'h21, BYTE, 1'b1, '0, CAUSE_NONE);
    do_access(1'b0, 1'b0, 32'h22, HWORD, 1'b0, '0, CAUSE_NONE);
    do_access(1'b0, 1'b0, 32'h22, HWORD, 1'b1, '0, CAUSE_NONE);
    do_access(1'b0, 1'b0, 32'h20, BYTE, 1'b1, '0, CAUSE_NONE);
    do_access(1'b0, 1'b0, 32'h20, HWORD, 1'b0, '0, CAUSE_NONE);
    report_test("byte and halfword lanes");

    begin_test();
    do_access(1'b0, 1'b0, 32'h11, HWORD, 1'b0, '0, CAUSE_MISALIGNED);
    do_access(1'b0, 1'b0, 32'h12, WORD, 1'b0, '0, CAUSE_MISALIGNED);
    d = $random(seed);
    do_access(1'b1, 1'b0, 32'h13, WORD, 1'b0, d, CAUSE_MISALIGNED);
    do_access(1'b0, 1'b0, 32'h10, lsu_size_t'(2'd3), 1'b0, '0, CAUSE_MISALIGNED);
    report_test("misaligned data access");

    // Fetch with we set still has to read
    begin_test();
    do_access(1'b0, 1'b1, 32'h12, WORD, 1'b0, '0, CAUSE_MISALIGNED);
    d = $random(seed);
    do_access(1'b1, 1'b1, 32'h10, WORD, 1'b0, d, CAUSE_NONE);
    report_test("instruction fetch alignment");

    begin_test();
    do_access(1'b0, 1'b0, 32'h100, WORD, 1'b0, '0, CAUSE_BUS_ERR);
    d = $random(seed);
    do_access(1'b1, 1'b0, 32'h104, WORD, 1'b0, d, CAUSE_BUS_ERR);
    do_access(1'b0, 1'b0, 32'h200, WORD, 1'b0, '0, CAUSE_TIMEOUT);
    do_access(1'b0, 1'b0, 32'h10, WORD, 1'b0, '0, CAUSE_NONE);
    report_test("bus error and timeout");

    repeat (2) @(posedge clk);
    $display("Tests: pass count %0d, fail count %0d, check errors %0d",
             pass_cnt, fail_cnt, errors);
    if (fail_cnt == 0 && errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // Watchdog sized for the worst case per request
  initial begin
    #(N_REQ * REQ_CYCLES * 8);
    $display("Watchdog expired before the tests finished");
    $display("Testbench failed");
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+rtl
rtl/lsu_pkg.sv
rtl/lsu_misalign_chk.sv
rtl/lsu_bus_timer.sv
rtl/lsu_lane_align.sv
rtl/lsu_ctrl_fsm.sv
rtl/lsu_top.sv
bench/lsu_apb_mem.sv
bench/lsu_tb.sv
